// File: include/ecg_settings.svh
`ifndef ECG_SETTINGS_SVH
`define ECG_SETTINGS_SVH

// block layout
`define ECG_NUM_GROUPS 4
`define ECG_SAMPLES 4

// field widths
`define ECG_SIZE_FIELD_BITS 3
`define ECG_SUFFIX_BITS 128
`define ECG_COEFF_BITS 9

`endif

// File: hw/ecg_pkg.sv
`include "ecg_settings.svh"

package ecg_pkg;

  typedef logic [`ECG_SUFFIX_BITS-1:0] suffix_t;
  typedef logic [`ECG_SIZE_FIELD_BITS-1:0] sample_bits_t;
  typedef logic [(1 << `ECG_SIZE_FIELD_BITS)-2:0] mag_t;
  // magnitudes of one group, left-aligned
  typedef logic [`ECG_SAMPLES*$bits(mag_t)-1:0] mag_field_t;
  // sample 0 in the top bits
  typedef logic [`ECG_SAMPLES*$bits(mag_t)-1:0] mag_group_t;
  typedef logic [`ECG_SAMPLES-1:0] nz_mask_t;
  typedef logic [`ECG_NUM_GROUPS*`ECG_SAMPLES-1:0] sign_field_t;
  // offsets and sizes, max 140
  typedef logic [7:0] bit_pos_t;
  typedef logic [`ECG_COEFF_BITS-1:0] coeff_t;
  typedef logic [`ECG_NUM_GROUPS*`ECG_SAMPLES*`ECG_COEFF_BITS-1:0] coeff_block_t;

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} hs_state_t;

endpackage

// File: hw/ecg_if.sv
interface ecg_if;

  ecg_pkg::sample_bits_t sample_bits;
  ecg_pkg::mag_field_t mag_field;
  logic load;
  ecg_pkg::mag_group_t mags;
  ecg_pkg::nz_mask_t nz_mask;
  logic mags_valid;

  modport feed (
    output sample_bits, mag_field, load
  );

  modport parse (
    input sample_bits, mag_field, load,
    output mags, nz_mask, mags_valid
  );

  modport drain (
    input sample_bits, mags, nz_mask, mags_valid
  );

endinterface

// File: hw/ecg_unpacker.sv
`include "ecg_settings.svh"

module ecg_unpacker (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 req,
  input  ecg_pkg::suffix_t     suffix,
  input  logic                 done,
  output logic                 ack,
  ecg_if.feed                  groups [`ECG_NUM_GROUPS],
  output ecg_pkg::sign_field_t sign_field,
  output ecg_pkg::bit_pos_t    mag_bits
);

  // zero tail, reads past bit 128 land here
  localparam int PAD_BITS = `ECG_NUM_GROUPS * `ECG_SAMPLES;
  localparam int WIN_BITS = `ECG_SUFFIX_BITS + PAD_BITS;
  localparam int MAG_FIELD_BITS = $bits(ecg_pkg::mag_field_t);

  ecg_pkg::hs_state_t state;
  ecg_pkg::suffix_t suffix_q;
  logic load;
  logic [WIN_BITS-1:0] window;
  logic [WIN_BITS-1:0] sign_win;
  ecg_pkg::bit_pos_t grp_off [`ECG_NUM_GROUPS+1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ecg_pkg::IDLE;
      ack <= 1'b0;
      load <= 1'b0;
    end else begin
      load <= 1'b0;
      case (state)
        ecg_pkg::IDLE: begin
          if (req) begin
            load <= 1'b1;
            state <= ecg_pkg::BUSY;
          end
        end
        ecg_pkg::BUSY: begin
          if (done) begin
            ack <= 1'b1;
            state <= ecg_pkg::HOLD;
          end
        end
        ecg_pkg::HOLD: begin
          // four-phase release
          if (!req) begin
            ack <= 1'b0;
            state <= ecg_pkg::IDLE;
          end
        end
        default: state <= ecg_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ecg_pkg::IDLE && req) begin
      suffix_q <= suffix;
    end
  end

  assign window = {suffix_q, {PAD_BITS{1'b0}}};
  assign grp_off[0] = '0;

  // each group starts 3 + 4n bits after the previous one
  for (genvar g = 0; g < `ECG_NUM_GROUPS; g++) begin : g_grp
    logic [WIN_BITS-1:0] grp_win;
    ecg_pkg::sample_bits_t n;

    assign grp_win = window << grp_off[g];
    assign n = grp_win[WIN_BITS-1 -: `ECG_SIZE_FIELD_BITS];
    assign groups[g].sample_bits = n;
    assign groups[g].mag_field = grp_win[WIN_BITS-1-`ECG_SIZE_FIELD_BITS -: MAG_FIELD_BITS];
    assign groups[g].load = load;
    assign grp_off[g+1] = grp_off[g] + ecg_pkg::bit_pos_t'(`ECG_SIZE_FIELD_BITS)
                          + ecg_pkg::bit_pos_t'(n) * ecg_pkg::bit_pos_t'(`ECG_SAMPLES);
  end

  // sign bits follow the last group
  assign mag_bits = grp_off[`ECG_NUM_GROUPS];
  assign sign_win = window << mag_bits;
  assign sign_field = sign_win[WIN_BITS-1 -: $bits(ecg_pkg::sign_field_t)];

  ack_idle_a: assert property (@(posedge clk) disable iff (!arst_n)
    (state == ecg_pkg::IDLE) |-> !ack);

endmodule

// File: hw/ecg_sample_parser.sv
`include "ecg_settings.svh"

module ecg_sample_parser (
  input logic  clk,
  input logic  arst_n,
  ecg_if.parse grp
);

  localparam int MAG_BITS = $bits(ecg_pkg::mag_t);
  localparam int FIELD_BITS = $bits(ecg_pkg::mag_field_t);

  ecg_pkg::mag_group_t mags_d;
  ecg_pkg::nz_mask_t nz_d;
  ecg_pkg::mag_group_t mags_q;
  ecg_pkg::nz_mask_t nz_q;
  logic valid_q;

  always_comb begin
    ecg_pkg::mag_field_t rest;
    ecg_pkg::mag_t mag;
    rest = grp.mag_field;
    for (int i = 0; i < `ECG_SAMPLES; i++) begin
      // top n bits of what is left, right-justified
      mag = rest[FIELD_BITS-1 -: MAG_BITS] >> (MAG_BITS - int'(grp.sample_bits));
      mags_d[(`ECG_SAMPLES-1-i)*MAG_BITS +: MAG_BITS] = mag;
      nz_d[i] = |mag;
      rest = rest << grp.sample_bits;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= grp.load;
    end
  end

  always_ff @(posedge clk) begin
    if (grp.load) begin
      mags_q <= mags_d;
      nz_q <= nz_d;
    end
  end

  assign grp.mags = mags_q;
  assign grp.nz_mask = nz_q;
  assign grp.mags_valid = valid_q;

  for (genvar i = 0; i < `ECG_SAMPLES; i++) begin : g_chk
    mag_range_a: assert property (@(posedge clk) disable iff (!arst_n)
      valid_q |-> ({1'b0, mags_q[(`ECG_SAMPLES-1-i)*MAG_BITS +: MAG_BITS]}
                   < (8'd1 << grp.sample_bits)));
  end

endmodule

// File: hw/ecg_sign_assembler.sv
`include "ecg_settings.svh"

module ecg_sign_assembler (
  input  logic                  clk,
  input  logic                  arst_n,
  ecg_if.drain                  groups [`ECG_NUM_GROUPS],
  input  ecg_pkg::sign_field_t  sign_field,
  input  ecg_pkg::bit_pos_t     mag_bits,
  output logic                  done,
  output ecg_pkg::coeff_block_t coeffs,
  output ecg_pkg::bit_pos_t     coef_size
);

  localparam int NUM_COEFFS = `ECG_NUM_GROUPS * `ECG_SAMPLES;
  localparam int MAG_BITS = $bits(ecg_pkg::mag_t);
  localparam int SIGN_BITS = $bits(ecg_pkg::sign_field_t);

  ecg_pkg::mag_t mag_all [NUM_COEFFS];
  logic [NUM_COEFFS-1:0] nz_all;
  logic [`ECG_NUM_GROUPS-1:0] valid_all;
  ecg_pkg::coeff_block_t coeffs_d;
  ecg_pkg::bit_pos_t nz_count;

  // flatten in bitstream order with group 0 sample 0 first
  for (genvar g = 0; g < `ECG_NUM_GROUPS; g++) begin : g_grp
    assign valid_all[g] = groups[g].mags_valid;
    for (genvar i = 0; i < `ECG_SAMPLES; i++) begin : g_smp
      assign mag_all[g*`ECG_SAMPLES+i] = groups[g].mags[(`ECG_SAMPLES-1-i)*MAG_BITS +: MAG_BITS];
      assign nz_all[g*`ECG_SAMPLES+i] = groups[g].nz_mask[i];
    end
  end

  always_comb begin
    ecg_pkg::bit_pos_t cnt;
    ecg_pkg::sign_field_t rest;
    ecg_pkg::coeff_t mag_ext;
    cnt = '0;
    coeffs_d = '0;
    for (int k = 0; k < NUM_COEFFS; k++) begin
      // prefix count picks this sample's sign bit
      rest = sign_field << cnt;
      mag_ext = ecg_pkg::coeff_t'(mag_all[k]);
      if (nz_all[k] && rest[SIGN_BITS-1]) begin
        coeffs_d[(NUM_COEFFS-1-k)*`ECG_COEFF_BITS +: `ECG_COEFF_BITS] = -mag_ext;
      end else begin
        coeffs_d[(NUM_COEFFS-1-k)*`ECG_COEFF_BITS +: `ECG_COEFF_BITS] = mag_ext;
      end
      cnt = cnt + ecg_pkg::bit_pos_t'(nz_all[k]);
    end
    nz_count = cnt;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
      coeffs <= '0;
      coef_size <= '0;
    end else begin
      done <= valid_all[0];
      if (valid_all[0]) begin
        coeffs <= coeffs_d;
        coef_size <= mag_bits + nz_count;
      end
    end
  end

  valid_align_a: assert property (@(posedge clk) disable iff (!arst_n)
    (|valid_all) |-> (&valid_all));

endmodule

// File: hw/ecg_decoder.sv
`include "ecg_settings.svh"

module ecg_decoder (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  req,
  input  ecg_pkg::suffix_t      suffix,
  output logic                  ack,
  output ecg_pkg::coeff_block_t coeffs,
  output ecg_pkg::bit_pos_t     coef_size
);

  logic done;
  ecg_pkg::sign_field_t sign_field;
  ecg_pkg::bit_pos_t mag_bits;

  ecg_if grp_if [`ECG_NUM_GROUPS] ();

  ecg_unpacker ecg_unpacker_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .suffix     (suffix),
    .done       (done),
    .ack        (ack),
    .groups     (grp_if),
    .sign_field (sign_field),
    .mag_bits   (mag_bits)
  );

  // one parser per group
  for (genvar g = 0; g < `ECG_NUM_GROUPS; g++) begin : g_parse
    ecg_sample_parser ecg_sample_parser_i (
      .clk    (clk),
      .arst_n (arst_n),
      .grp    (grp_if[g])
    );
  end

  ecg_sign_assembler ecg_sign_assembler_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .groups     (grp_if),
    .sign_field (sign_field),
    .mag_bits   (mag_bits),
    .done       (done),
    .coeffs     (coeffs),
    .coef_size  (coef_size)
  );

endmodule

// File: verification/ecg_decoder_tb.sv
`include "ecg_settings.svh"

module ecg_decoder_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_GROUPS = `ECG_NUM_GROUPS;
  localparam int SAMPLES = `ECG_SAMPLES;
  localparam int NUM_COEFFS = NUM_GROUPS * SAMPLES;
  localparam int SUFFIX_BITS = `ECG_SUFFIX_BITS;
  localparam int COEFF_BITS = `ECG_COEFF_BITS;
  localparam int NUM_RANDOM = 40;
  localparam int NUM_BLOCKS = 3 + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 40 + 100;

  logic clk;
  logic arst_n;
  logic req;
  ecg_pkg::suffix_t suffix;
  logic ack;
  ecg_pkg::coeff_block_t coeffs;
  ecg_pkg::bit_pos_t coef_size;

  integer seed = 32'h38c0;
  int errors;
  int blocks;
  int cycles;
  logic req_seen;
  logic [7:0] req_edges;
  ecg_pkg::coeff_block_t exp_coeffs;
  ecg_pkg::bit_pos_t exp_size;

  // fields of the block being built
  int sz [NUM_GROUPS];
  int mg [NUM_COEFFS];
  logic [NUM_COEFFS-1:0] sg;

  ecg_decoder ecg_decoder_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .suffix    (suffix),
    .ack       (ack),
    .coeffs    (coeffs),
    .coef_size (coef_size)
  );

  always #5 clk = ~clk;

  // edges that sampled req high in the current request
  always @(posedge clk) begin
    if (!arst_n || !req) begin
      req_edges <= '0;
    end else if (req_edges != 8'hff) begin
      req_edges <= req_edges + 8'd1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      errors++;
      $display("timeout after %0d cycles, handshake stalled in block %0d", TIMEOUT_CYCLES, blocks);
      $display("errors: %0d, blocks: %0d of %0d", errors, blocks, NUM_BLOCKS);
      $display("Result: FAILED");
      $finish;
    end
  end

  reset_ack_a: assert property (@(posedge clk) disable iff (!arst_n) !req_seen |-> !ack)
    else begin
      errors++;
      $display("FAIL ack: expected 0 before the first req, got %h", ack);
    end

  reset_size_a: assert property (@(posedge clk) disable iff (!arst_n)
    !req_seen |-> coef_size == '0)
    else begin
      errors++;
      $display("FAIL coef_size: expected 00 before the first req, got %h", coef_size);
    end

  // capture edge plus three more
  ack_delay_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> req_edges == 8'd4)
    else begin
      errors++;
      $display("ack rose with req high for %0d edges, not three edges after capture", req_edges);
    end

  coeffs_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> coeffs == exp_coeffs)
    else begin
      errors++;
      $display("FAIL coeffs: expected %h, got %h", exp_coeffs, coeffs);
    end

  size_a: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> coef_size == exp_size)
    else begin
      errors++;
      $display("FAIL coef_size: expected %h, got %h", exp_size, coef_size);
    end

  hold_ack_a: assert property (@(posedge clk) disable iff (!arst_n) (ack && req) |=> ack)
    else begin
      errors++;
      $display("ack dropped while req was still high");
    end

  hold_data_a: assert property (@(posedge clk) disable iff (!arst_n)
    (ack && $past(ack)) |-> ($stable(coeffs) && $stable(coef_size)))
    else begin
      errors++;
      $display("coeffs or coef_size changed while ack was held high");
    end

  release_a: assert property (@(posedge clk) disable iff (!arst_n) (ack && !req) |=> !ack)
    else begin
      errors++;
      $display("ack stayed high after req was sampled low");
    end

  idle_a: assert property (@(posedge clk) disable iff (!arst_n) (!ack && !req) |=> !ack)
    else begin
      errors++;
      $display("ack rose without a request");
    end

  // stream bit p sits at suffix bit 127-p, zero past the window
  function automatic int read_bits(input ecg_pkg::suffix_t s, input int pos, input int width);
    int val;
    val = 0;
    for (int i = 0; i < width; i++) begin
      val = val << 1;
      if (pos + i < SUFFIX_BITS) begin
        val = val | int'(s[SUFFIX_BITS-1-pos-i]);
      end
    end
    return val;
  endfunction

  function automatic ecg_pkg::coeff_block_t decode_model(input ecg_pkg::suffix_t s,
                                                         output int size);
    int pos;
    int n;
    int mag [NUM_COEFFS];
    ecg_pkg::coeff_block_t blk;
    pos = 0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      n = read_bits(s, pos, `ECG_SIZE_FIELD_BITS);
      pos += `ECG_SIZE_FIELD_BITS;
      for (int i = 0; i < SAMPLES; i++) begin
        mag[g*SAMPLES+i] = read_bits(s, pos, n);
        pos += n;
      end
    end
    blk = '0;
    for (int k = 0; k < NUM_COEFFS; k++) begin
      if (mag[k] != 0) begin
        if (read_bits(s, pos, 1) == 1) begin
          blk[(NUM_COEFFS-1-k)*COEFF_BITS +: COEFF_BITS] = ecg_pkg::coeff_t'(-mag[k]);
        end else begin
          blk[(NUM_COEFFS-1-k)*COEFF_BITS +: COEFF_BITS] = ecg_pkg::coeff_t'(mag[k]);
        end
        pos += 1;
      end
    end
    size = pos;
    return blk;
  endfunction

  function automatic void put_bits(inout ecg_pkg::suffix_t s, inout int pos,
                                   input int val, input int width);
    for (int i = width - 1; i >= 0; i--) begin
      if (pos < SUFFIX_BITS) begin
        s[SUFFIX_BITS-1-pos] = val[i];
      end
      pos++;
    end
  endfunction

  task automatic set_group(input int g, input int n, input int m0, input int m1,
                           input int m2, input int m3);
    sz[g] = n;
    mg[g*SAMPLES] = m0;
    mg[g*SAMPLES+1] = m1;
    mg[g*SAMPLES+2] = m2;
    mg[g*SAMPLES+3] = m3;
  endtask

  // bits after the last sign bit keep the fill value
  task automatic build_suffix(input ecg_pkg::suffix_t fill, output ecg_pkg::suffix_t s);
    int pos;
    s = fill;
    pos = 0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      put_bits(s, pos, sz[g], `ECG_SIZE_FIELD_BITS);
      for (int i = 0; i < SAMPLES; i++) begin
        put_bits(s, pos, mg[g*SAMPLES+i], sz[g]);
      end
    end
    for (int k = 0; k < NUM_COEFFS; k++) begin
      if (mg[k] != 0) begin
        put_bits(s, pos, int'(sg[k]), 1);
      end
    end
  endtask

  task automatic random_block(output ecg_pkg::suffix_t s);
    ecg_pkg::suffix_t fill;
    fill = {$random(seed), $random(seed), $random(seed), $random(seed)};
    for (int g = 0; g < NUM_GROUPS; g++) begin
      sz[g] = $random(seed) & 7;
      for (int i = 0; i < SAMPLES; i++) begin
        mg[g*SAMPLES+i] = $random(seed) & ((1 << sz[g]) - 1);
      end
    end
    sg = 16'($random(seed));
    build_suffix(fill, s);
  endtask

  task automatic run_block(input ecg_pkg::suffix_t s, input int hold);
    int size;
    exp_coeffs = decode_model(s, size);
    exp_size = ecg_pkg::bit_pos_t'(size);
    suffix = s;
    req = 1'b1;
    req_seen = 1'b1;
    while (!ack) begin
      @(posedge clk);
      #1;
    end
    // suffix is free once ack is up
    suffix = ~s;
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    while (ack) begin
      @(posedge clk);
      #1;
    end
    blocks++;
  endtask

  initial begin
    ecg_pkg::suffix_t s;
    clk = 1'b0;
    arst_n = 1'b0;
    req = 1'b0;
    suffix = '0;
    req_seen = 1'b0;
    exp_coeffs = '0;
    exp_size = '0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (4) @(posedge clk);
    #1;

    // empty groups, trailing ones must not count
    for (int g = 0; g < NUM_GROUPS; g++) begin
      set_group(g, 0, 0, 0, 0, 0);
    end
    sg = '1;
    build_suffix('1, s);
    run_block(s, 0);

    // full size 7, 140 bits so the last sign bits read as zero
    for (int k = 0; k < NUM_COEFFS; k++) begin
      mg[k] = (k * 37 + 11) & 127;
    end
    for (int g = 0; g < NUM_GROUPS; g++) begin
      sz[g] = 7;
    end
    mg[0] = 127;
    mg[NUM_COEFFS-1] = 1;
    sg = 16'ha5c3;
    build_suffix('0, s);
    run_block(s, 5);

    set_group(0, 3, 5, 0, 7, 1);
    set_group(1, 7, 0, 64, 63, 0);
    set_group(2, 1, 1, 0, 1, 1);
    set_group(3, 4, 0, 0, 15, 8);
    sg = 16'h6b2d;
    build_suffix('0, s);
    run_block(s, 2);

    for (int b = 0; b < NUM_RANDOM; b++) begin
      random_block(s);
      run_block(s, $random(seed) & 3);
    end

    repeat (3) @(posedge clk);
    #1;
    $display("errors: %0d, blocks: %0d of %0d", errors, blocks, NUM_BLOCKS);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: ecg_decoder.f
+incdir+include
hw/ecg_pkg.sv
hw/ecg_if.sv
hw/ecg_unpacker.sv
hw/ecg_sample_parser.sv
hw/ecg_sign_assembler.sv
hw/ecg_decoder.sv
verification/ecg_decoder_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ecg_decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vecg_decoder_tb

verilator --binary --assert -f ecg_decoder.f --top-module ecg_decoder_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
